// ==== common/pool_geom_pkg.sv ====
package pool_geom_pkg;

	//////////////////////////////////////////////////
	// Image geometry
	//////////////////////////////////////////////////

	// Pixels per row and rows per frame
	localparam int IMAGE_WIDTH  = 8;
	localparam int IMAGE_HEIGHT = 8;

	// Channels interleaved inside one pixel position
	localparam int CHANNELS = 2;

	// Unsigned pixel value width
	localparam int DATA_WIDTH = 8;

	//////////////////////////////////////////////////
	// Derived sizes
	//////////////////////////////////////////////////

	// One image row of beats, all channels included
	localparam int ROW_DEPTH = IMAGE_WIDTH * CHANNELS;

	// Counter widths
	localparam int COL_BITS  = $clog2(IMAGE_WIDTH);
	localparam int ROW_BITS  = $clog2(IMAGE_HEIGHT);
	localparam int CH_BITS   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
	localparam int ADDR_BITS = $clog2(ROW_DEPTH);

endpackage

// ==== common/pool_stream_pkg.sv ====
package pool_stream_pkg;

	//////////////////////////////////////////////////
	// Stream payloads
	//////////////////////////////////////////////////

	// One input beat, a single channel of one pixel
	typedef struct packed {
		logic [pool_geom_pkg::DATA_WIDTH-1:0] value;
	} pixel_beat_t;

	// 3x3 window, row-major from top-left
	typedef struct packed {
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p00;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p01;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p02;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p10;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p11;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p12;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p20;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p21;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] p22;
		logic [pool_geom_pkg::CH_BITS-1:0]    ch;
	} window_t;

	// Pooled maximum with the channel it came from
	typedef struct packed {
		logic [pool_geom_pkg::DATA_WIDTH-1:0] value;
		logic [pool_geom_pkg::CH_BITS-1:0]    ch;
	} pool_result_t;

	// Window buffer fill progress within a frame
	typedef enum logic [1:0] {
		FILL_ROWS,
		STREAMING,
		FRAME_DONE
	} fill_state_t;

endpackage

// ==== window_buffer/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         shift,
	input  pool_stream_pkg::pixel_beat_t din,
	output pool_stream_pkg::pixel_beat_t dout
);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	pool_stream_pkg::pixel_beat_t mem [pool_geom_pkg::ROW_DEPTH];

	// Circular pointer, always at the oldest entry
	logic [pool_geom_pkg::ADDR_BITS-1:0] addr;
	logic                                addr_last;

	assign addr_last = (addr == pool_geom_pkg::ADDR_BITS'(pool_geom_pkg::ROW_DEPTH - 1));

	// Oldest entry is visible before it gets overwritten
	assign dout = mem[addr];

	//////////////////////////////////////////////////
	// Pointer and write
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			addr <= '0;
		end else if (shift) begin
			if (addr_last) begin
				addr <= '0;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

	// New beat takes the slot just read out
	always_ff @(posedge clk) begin
		if (shift) begin
			mem[addr] <= din;
		end
	end

endmodule

// ==== window_buffer/window_buffer.sv ====
`timescale 1ns/1ps

module window_buffer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         valid_in,
	input  pool_stream_pkg::pixel_beat_t pix_in,
	output logic                         win_valid,
	output pool_stream_pkg::window_t     win
);

	//////////////////////////////////////////////////
	// Position counters
	//////////////////////////////////////////////////

	logic [pool_geom_pkg::CH_BITS-1:0]  ch_cnt;
	logic [pool_geom_pkg::COL_BITS-1:0] col_cnt;
	logic [pool_geom_pkg::ROW_BITS-1:0] row_cnt;
	logic                               ch_end;
	logic                               col_end;
	logic                               row_end;
	logic                               emit;

	pool_stream_pkg::fill_state_t state;
	pool_stream_pkg::fill_state_t state_next;

	assign ch_end  = (ch_cnt == pool_geom_pkg::CH_BITS'(pool_geom_pkg::CHANNELS - 1));
	assign col_end = (col_cnt == pool_geom_pkg::COL_BITS'(pool_geom_pkg::IMAGE_WIDTH - 1));
	assign row_end = (row_cnt == pool_geom_pkg::ROW_BITS'(pool_geom_pkg::IMAGE_HEIGHT - 1));

	// Channel fastest, then column, then row
	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt  <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (valid_in) begin
			if (ch_end) begin
				ch_cnt <= '0;
				if (col_end) begin
					col_cnt <= '0;
					row_cnt <= row_end ? '0 : row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end else begin
				ch_cnt <= ch_cnt + 1'b1;
			end
		end
	end

	// Stride 2 without padding needs even row and column of at least 2
	assign emit = valid_in && !row_cnt[0] && (|row_cnt) && !col_cnt[0] && (|col_cnt);

	//////////////////////////////////////////////////
	// Fill state
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			pool_stream_pkg::FILL_ROWS: begin
				// Last beat of row 1 leaves two rows buffered
				if (valid_in && row_cnt == pool_geom_pkg::ROW_BITS'(1) && col_end && ch_end) begin
					state_next = pool_stream_pkg::STREAMING;
				end
			end
			pool_stream_pkg::STREAMING: begin
				if (valid_in && row_end && col_end && ch_end) begin
					state_next = pool_stream_pkg::FRAME_DONE;
				end
			end
			default: begin
				state_next = pool_stream_pkg::FILL_ROWS;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pool_stream_pkg::FILL_ROWS;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////
	// Row taps
	//////////////////////////////////////////////////

	pool_stream_pkg::pixel_beat_t row1_tap;
	pool_stream_pkg::pixel_beat_t row2_tap;

	line_buffer line_buffer_0 (
		.clk   (clk),
		.reset (reset),
		.shift (valid_in),
		.din   (pix_in),
		.dout  (row1_tap)
	);

	line_buffer line_buffer_1 (
		.clk   (clk),
		.reset (reset),
		.shift (valid_in),
		.din   (row1_tap),
		.dout  (row2_tap)
	);

	//////////////////////////////////////////////////
	// Column registers and window output
	//////////////////////////////////////////////////

	// Index 0 is the top row and index 2 the current row
	pool_stream_pkg::pixel_beat_t taps [3];
	pool_stream_pkg::pixel_beat_t col_a [pool_geom_pkg::CHANNELS][3];
	pool_stream_pkg::pixel_beat_t col_b [pool_geom_pkg::CHANNELS][3];

	assign taps[0] = row2_tap;
	assign taps[1] = row1_tap;
	assign taps[2] = pix_in;

	// col_a holds column c-2 and col_b column c-1
	always_ff @(posedge clk) begin
		if (valid_in) begin
			for (int i = 0; i < 3; i++) begin
				col_a[ch_cnt][i] <= col_b[ch_cnt][i];
				col_b[ch_cnt][i] <= taps[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			win.p00 <= col_a[ch_cnt][0].value;
			win.p01 <= col_b[ch_cnt][0].value;
			win.p02 <= taps[0].value;
			win.p10 <= col_a[ch_cnt][1].value;
			win.p11 <= col_b[ch_cnt][1].value;
			win.p12 <= taps[1].value;
			win.p20 <= col_a[ch_cnt][2].value;
			win.p21 <= col_b[ch_cnt][2].value;
			win.p22 <= taps[2].value;
			win.ch  <= ch_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= emit;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Position counters and line buffer pointer advance together
	col_tracks_addr: assert property (@(posedge clk) disable iff (reset)
		int'(line_buffer_0.addr)
			== int'(col_cnt) * pool_geom_pkg::CHANNELS + int'(ch_cnt));

	// Counters and fill state must agree on when windows exist
	no_win_while_filling: assert property (@(posedge clk) disable iff (reset)
		win_valid |-> state != pool_stream_pkg::FILL_ROWS);

endmodule

// ==== verilog/max_tree.sv ====
`timescale 1ns/1ps

module max_tree (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          win_valid,
	input  pool_stream_pkg::window_t      win,
	output logic                          valid_out,
	output pool_stream_pkg::pool_result_t result
);

	function automatic logic [pool_geom_pkg::DATA_WIDTH-1:0] max3(
		input logic [pool_geom_pkg::DATA_WIDTH-1:0] a,
		input logic [pool_geom_pkg::DATA_WIDTH-1:0] b,
		input logic [pool_geom_pkg::DATA_WIDTH-1:0] c
	);
		logic [pool_geom_pkg::DATA_WIDTH-1:0] ab;
		ab = (a > b) ? a : b;
		return (ab > c) ? ab : c;
	endfunction

	//////////////////////////////////////////////////
	// Stage 1, per-row maxima
	//////////////////////////////////////////////////

	logic [pool_geom_pkg::DATA_WIDTH-1:0] row_max [3];
	logic [pool_geom_pkg::CH_BITS-1:0]    ch_s1;
	logic                                 valid_s1;

	always_ff @(posedge clk) begin
		if (win_valid) begin
			row_max[0] <= max3(win.p00, win.p01, win.p02);
			row_max[1] <= max3(win.p10, win.p11, win.p12);
			row_max[2] <= max3(win.p20, win.p21, win.p22);
			ch_s1      <= win.ch;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= win_valid;
		end
	end

	//////////////////////////////////////////////////
	// Stage 2, final maximum
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (valid_s1) begin
			result.value <= max3(row_max[0], row_max[1], row_max[2]);
			result.ch    <= ch_s1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_s1;
		end
	end

	// Catches windows built from unwritten line buffer rows
	result_known: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> !$isunknown(result));

endmodule

// ==== verilog/maxpool_3x3.sv ====
`timescale 1ns/1ps

module maxpool_3x3 (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          valid_in,
	input  pool_stream_pkg::pixel_beat_t  pix_in,
	output logic                          valid_out,
	output pool_stream_pkg::pool_result_t result
);

	//////////////////////////////////////////////////
	// Window assembly to compare tree
	//////////////////////////////////////////////////

	logic                     win_valid;
	pool_stream_pkg::window_t win;

	// Window lands one cycle after the completing beat
	window_buffer window_buffer_i (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pix_in    (pix_in),
		.win_valid (win_valid),
		.win       (win)
	);

	// Two more cycles to the pooled result
	max_tree max_tree_i (
		.clk       (clk),
		.reset     (reset),
		.win_valid (win_valid),
		.win       (win),
		.valid_out (valid_out),
		.result    (result)
	);

endmodule

// ==== tests/maxpool_tb.sv ====
`timescale 1ns/1ps

module maxpool_tb;

	//////////////////////////////////////////////////
	// Stimulus file layout
	//////////////////////////////////////////////////

	localparam int ROW_WORDS    = pool_geom_pkg::IMAGE_WIDTH * pool_geom_pkg::CHANNELS;
	localparam int PIXEL_WORDS  = ROW_WORDS * pool_geom_pkg::IMAGE_HEIGHT;
	localparam int RESULT_WORDS = ((pool_geom_pkg::IMAGE_HEIGHT - 1) / 2)
		* ((pool_geom_pkg::IMAGE_WIDTH - 1) / 2) * pool_geom_pkg::CHANNELS;
	localparam int FRAME_WORDS  = PIXEL_WORDS + RESULT_WORDS;
	localparam int FILE_WORDS   = 2 * FRAME_WORDS;

	// Accepting edge to valid_out at the sampling edge
	localparam int LATENCY     = 3;
	localparam int DRAIN_LIMIT = 64;
	localparam int IDLE_TAIL   = 20;

	typedef struct packed {
		int                                   due;
		logic [pool_geom_pkg::DATA_WIDTH-1:0] value;
		logic [pool_geom_pkg::CH_BITS-1:0]    ch;
	} expected_t;

	logic                          clk;
	logic                          reset;
	logic                          valid_in;
	pool_stream_pkg::pixel_beat_t  pix_in;
	logic                          valid_out;
	pool_stream_pkg::pool_result_t result;

	logic [pool_geom_pkg::DATA_WIDTH-1:0] file_words [FILE_WORDS];

	// Scoreboard filled by the stimulus and consumed in order by the monitor
	expected_t expect_q[$];
	int        check_index  = 0;
	int        cycle        = 0;
	int        result_count = 0;
	int        check_errors = 0;

	logic        checking;
	logic [31:0] rng_state;
	int          flow_errors;
	bit          timed_out;
	int          tests_run;
	int          tests_failed;

	maxpool_3x3 maxpool_3x3_i (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pix_in    (pix_in),
		.valid_out (valid_out),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (checking) begin
			// Every strobe counts, expected or not
			if (valid_out === 1'b1) begin
				result_count++;
			end
			if (check_index < expect_q.size() && expect_q[check_index].due == cycle) begin
				assert (valid_out === 1'b1) else begin
					$display("MISMATCH valid_out got %h expected 1 at cycle %0d", valid_out, cycle);
					check_errors++;
				end
				if (valid_out === 1'b1) begin
					assert (result.value === expect_q[check_index].value) else begin
						$display("MISMATCH result.value got %h expected %h at cycle %0d",
							result.value, expect_q[check_index].value, cycle);
						check_errors++;
					end
					assert (result.ch === expect_q[check_index].ch) else begin
						$display("MISMATCH result.ch got %h expected %h at cycle %0d",
							result.ch, expect_q[check_index].ch, cycle);
						check_errors++;
					end
				end
				check_index++;
			end else begin
				// Strobe stays low when nothing is due
				assert (valid_out === 1'b0) else begin
					$display("MISMATCH valid_out got %h expected 0 at cycle %0d", valid_out, cycle);
					check_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Stride 2 without padding
	function automatic bit window_completes(input int r, input int c);
		return (r >= 2) && (r % 2 == 0) && (c >= 2) && (c % 2 == 0);
	endfunction

	function automatic int pixel_word(input int frame, input int r, input int c, input int k);
		return frame * FRAME_WORDS + r * ROW_WORDS + c * pool_geom_pkg::CHANNELS + k;
	endfunction

	function automatic int total_errors();
		return check_errors + flow_errors;
	endfunction

	task automatic hold_reset();
		reset    <= 1'b1;
		valid_in <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic go_idle();
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	task automatic drive_frame(input int frame, input int rows, input bit gaps,
		output int pushed);
		int        idle;
		int        i;
		expected_t item;
		pushed = 0;
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < pool_geom_pkg::IMAGE_WIDTH; c++) begin
				for (int k = 0; k < pool_geom_pkg::CHANNELS; k++) begin
					if (gaps) begin
						rng_state = next_random(rng_state);
						idle      = int'(rng_state[1:0]);
						for (i = 0; i < idle; i++) begin
							@(posedge clk);
							valid_in     <= 1'b0;
							// Junk on the data lines while idle
							pix_in.value <= pool_geom_pkg::DATA_WIDTH'(rng_state >> 8);
						end
					end
					@(posedge clk);
					valid_in     <= 1'b1;
					pix_in.value <= file_words[pixel_word(frame, r, c, k)];
					if (window_completes(r, c)) begin
						// Beat is accepted on the next edge
						item.due   = cycle + 1 + LATENCY;
						item.value = file_words[frame * FRAME_WORDS + PIXEL_WORDS + pushed];
						item.ch    = pool_geom_pkg::CH_BITS'(k);
						expect_q.push_back(item);
						pushed++;
					end
				end
			end
		end
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (check_index < expect_q.size() && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (check_index == expect_q.size()) else begin
			$display("ERROR: gave up after %0d cycles with %0d results still outstanding",
				waited, expect_q.size() - check_index);
			flow_errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_count(input int start, input int want);
		assert (result_count - start == want) else begin
			$display("ERROR: saw %0d results where %0d were expected", result_count - start, want);
			flow_errors++;
		end
	endtask

	task automatic end_test(input int num, input string name, input int errors_before);
		tests_run++;
		if (total_errors() == errors_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name,
				total_errors() - errors_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int err_before;
		int start;
		int pushed;
		int i;
		reset        = 1'b1;
		valid_in     = 1'b0;
		pix_in       = '0;
		checking     = 1'b0;
		flow_errors  = 0;
		timed_out    = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		rng_state    = 32'h3c69;
		$readmemh("tests/pool_input.txt", file_words);
		hold_reset();
		checking <= 1'b1;

		err_before = total_errors();
		start      = result_count;
		drive_frame(0, pool_geom_pkg::IMAGE_HEIGHT, 1'b0, pushed);
		go_idle();
		wait_for_results();
		check_count(start, RESULT_WORDS);
		end_test(1, "frame 1 back to back beats", err_before);

		if (!timed_out) begin
			err_before = total_errors();
			start      = result_count;
			drive_frame(1, pool_geom_pkg::IMAGE_HEIGHT, 1'b1, pushed);
			go_idle();
			wait_for_results();
			check_count(start, RESULT_WORDS);
			end_test(2, "frame 2 with random idle gaps", err_before);
		end

		// No idle cycle at the frame boundary
		if (!timed_out) begin
			err_before = total_errors();
			start      = result_count;
			drive_frame(0, pool_geom_pkg::IMAGE_HEIGHT, 1'b0, pushed);
			drive_frame(1, pool_geom_pkg::IMAGE_HEIGHT, 1'b0, pushed);
			go_idle();
			wait_for_results();
			check_count(start, 2 * RESULT_WORDS);
			end_test(3, "two frames without a boundary gap", err_before);
		end

		if (!timed_out) begin
			err_before = total_errors();
			start      = result_count;
			drive_frame(0, pool_geom_pkg::IMAGE_HEIGHT / 2, 1'b0, pushed);
			go_idle();
			wait_for_results();
			check_count(start, pushed);
			hold_reset();
			start = result_count;
			drive_frame(0, pool_geom_pkg::IMAGE_HEIGHT, 1'b0, pushed);
			go_idle();
			wait_for_results();
			check_count(start, RESULT_WORDS);
			end_test(4, "reset in mid frame then frame 1", err_before);
		end

		if (!timed_out) begin
			err_before = total_errors();
			start      = result_count;
			for (i = 0; i < IDLE_TAIL; i++) begin
				@(posedge clk);
			end
			check_count(start, 0);
			end_test(5, "quiet output while idle", err_before);
		end

		$display("%0d tests run, %0d failed, %0d results checked, %0d errors",
			tests_run, tests_failed, result_count, total_errors());
		if (total_errors() == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/pool_input.txt ====
// Per frame: 8 pixel rows of 16 bytes, ch0 ch1 for columns 0 to 7,
// then 3 result rows of 6 bytes, ch0 ch1 for window columns 2 4 6
// Frame 1, ramp up in channel 0 and ramp down in channel 1
00 ff 01 fe 02 fd 03 fc 04 fb 05 fa 06 f9 07 f8
10 ef 11 ee 12 ed 13 ec 14 eb 15 ea 16 e9 17 e8
20 df 21 de 22 dd 23 dc 24 db 25 da 26 d9 27 d8
30 cf 31 ce 32 cd 33 cc 34 cb 35 ca 36 c9 37 c8
40 bf 41 be 42 bd 43 bc 44 bb 45 ba 46 b9 47 b8
50 af 51 ae 52 ad 53 ac 54 ab 55 aa 56 a9 57 a8
60 9f 61 9e 62 9d 63 9c 64 9b 65 9a 66 99 67 98
70 8f 71 8e 72 8d 73 8c 74 8b 75 8a 76 89 77 88
// Frame 1 results, window row 2
22 ff 24 fd 26 fb
// Window row 4
42 df 44 dd 46 db
// Window row 6
62 bf 64 bd 66 bb
// Frame 2, flat background with isolated peaks
// Peaks in row 7 and column 7 fall outside every window
11 40 90 40 11 40 11 40 11 40 11 40 11 40 11 ff
11 40 11 40 11 40 11 40 11 40 55 40 11 40 11 40
11 40 11 40 11 f0 11 40 11 40 11 40 11 40 11 40
11 40 11 20 11 40 a5 40 11 40 11 40 11 40 11 40
11 40 11 40 11 40 11 40 11 40 11 40 11 9a 11 40
11 40 11 40 11 40 11 40 11 40 11 40 7e 40 11 40
c3 40 11 40 11 40 11 63 11 40 11 40 11 40 11 40
11 40 11 40 11 40 11 40 11 40 11 40 11 40 ee 40
// Frame 2 results, window row 2
90 f0 11 f0 55 40
// Window row 4
11 f0 a5 f0 11 9a
// Window row 6
c3 40 11 63 7e 9a

// ==== maxpool.f ====
common/pool_geom_pkg.sv
common/pool_stream_pkg.sv
window_buffer/line_buffer.sv
window_buffer/window_buffer.sv
verilog/max_tree.sv
verilog/maxpool_3x3.sv
tests/maxpool_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the max-pooling testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert \
	-f maxpool.f \
	--top-module maxpool_tb \
	-Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$("./$build_dir/Vmaxpool_tb" 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
